/* rtl/nnc_pkg.sv */
`default_nettype none

package nnc_pkg;

    typedef enum logic [3:0] {
        OP_NOP      = 4'h0,
        OP_SETREG   = 4'h1,
        OP_LOAD_RDN = 4'h2,
        OP_LOAD_DNN = 4'h3,
        OP_PROC     = 4'h4,
        OP_HALT     = 4'h5
    } opcode_e;

    typedef enum logic [1:0] {
        SEL_IMG_ADDR  = 2'd0,
        SEL_IMG_CNT   = 2'd1,
        SEL_RSLT_ADDR = 2'd2
    } reg_sel_e;

    // loads and runs carry a 28-bit address
    typedef struct packed {
        opcode_e     op;
        logic [27:0] arg;
    } instr_cmd_t;

    typedef struct packed {
        opcode_e     op;
        reg_sel_e    sel;
        logic [1:0]  spare;
        logic [23:0] val;
    } instr_reg_t;

    typedef union packed {
        instr_cmd_t cmd;
        instr_reg_t regv;
    } instr_u;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        FETCH_WAIT,
        EXEC,
        LOAD_WAIT,
        IMG_WAIT,
        RES_WAIT,
        WRITE_WAIT
    } seq_state_e;

endpackage

`default_nettype wire

/* rtl/nnc_regs.sv */
`default_nettype none

module nnc_regs (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                reg_wr,
    input  wire nnc_pkg::reg_sel_e reg_sel,
    input  wire         [23:0] reg_val,
    input  wire                img_addr_inc,
    input  wire                img_cnt_dec,
    input  wire                rslt_addr_inc,
    output logic        [27:0] img_addr,
    output logic               img_cnt_zero,
    output logic        [27:0] rslt_addr
);

    logic [23:0] img_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            img_addr  <= '0;
            img_cnt   <= '0;
            rslt_addr <= '0;
        end else if (reg_wr) begin
            // a program write overrides the running updates
            case (reg_sel)
                nnc_pkg::SEL_IMG_ADDR:  img_addr  <= 28'(reg_val);
                nnc_pkg::SEL_IMG_CNT:   img_cnt   <= reg_val;
                nnc_pkg::SEL_RSLT_ADDR: rslt_addr <= 28'(reg_val);
                default: ;
            endcase
        end else begin
            if (img_addr_inc) begin
                img_addr <= img_addr + 28'd1;
            end
            if (img_cnt_dec && img_cnt != '0) begin
                img_cnt <= img_cnt - 24'd1;
            end
            if (rslt_addr_inc) begin
                rslt_addr <= rslt_addr + 28'd1;
            end
        end
    end

    assign img_cnt_zero = (img_cnt == '0);

endmodule

`default_nettype wire

/* rtl/nnc_page_buf.sv */
`default_nettype none

module nnc_page_buf #(
    parameter int DATA_W     = 64,
    parameter int PROG_PAGES = 8,
    localparam int IDX_W     = $clog2(PROG_PAGES),
    localparam int PC_W      = $clog2(2 * PROG_PAGES)
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              pg_wr,
    input  wire  [IDX_W-1:0] pg_idx,
    input  wire [DATA_W-1:0] pg_data,
    input  wire   [PC_W-1:0] pc,
    output nnc_pkg::instr_u  instr
);

    logic [DATA_W-1:0]     pages [PROG_PAGES];
    logic [PROG_PAGES-1:0] loaded;
    logic [DATA_W-1:0]     page;

    always_ff @(posedge clk) begin
        if (pg_wr) begin
            pages[pg_idx] <= pg_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loaded <= '0;
        end else if (pg_wr) begin
            loaded[pg_idx] <= 1'b1;
        end
    end

    // even pc in the low word, odd pc in the next one
    always_comb begin
        page = pages[pc[PC_W-1:1]];
        if (!loaded[pc[PC_W-1:1]]) begin
            instr = '0;
        end else if (pc[0]) begin
            instr = page[32 +: 32];
        end else begin
            instr = page[31:0];
        end
    end

endmodule

`default_nettype wire

/* rtl/nnc_decode.sv */
`default_nettype none

module nnc_decode #(
    parameter int PROG_PAGES = 8,
    localparam int PC_W      = $clog2(2 * PROG_PAGES)
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     exec_en,
    input  wire                     next_instr,
    input  wire nnc_pkg::instr_u    instr,
    output logic         [PC_W-1:0] pc,
    output logic                    cmd_vld,
    output nnc_pkg::opcode_e        cmd_op,
    output logic             [27:0] cmd_arg,
    output logic                    reg_wr,
    output nnc_pkg::reg_sel_e       reg_sel,
    output logic             [23:0] reg_val
);

    localparam logic [PC_W-1:0] PC_LAST = PC_W'(2 * PROG_PAGES - 1);

    logic exec_q;
    logic active;

    // first cycle of exec_en only resets the pc
    assign active  = exec_en && exec_q;
    assign reg_wr  = active && (instr.cmd.op == nnc_pkg::OP_SETREG);
    assign cmd_vld = active && (instr.cmd.op != nnc_pkg::OP_SETREG);

    assign cmd_op  = instr.cmd.op;
    assign cmd_arg = instr.cmd.arg;
    assign reg_sel = instr.regv.sel;
    assign reg_val = instr.regv.val;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exec_q <= 1'b0;
            pc     <= '0;
        end else begin
            exec_q <= exec_en;
            if (exec_en && !exec_q) begin
                pc <= '0;
            end else if ((next_instr || reg_wr) && pc != PC_LAST) begin
                pc <= pc + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/nnc_seq.sv */
`default_nettype none

module nnc_seq #(
    parameter int DATA_W       = 64,
    parameter int PROG_PAGES   = 8,
    parameter int WEIGHT_PAGES = 4,
    parameter int IMG_PAGES    = 6,
    localparam int IDX_W       = $clog2(PROG_PAGES)
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                start,
    input  wire         [31:0] prog_base,
    output logic               read_req,
    output logic               write_req,
    output logic        [31:0] address,
    output logic  [DATA_W-1:0] write_data,
    input  wire                data_valid,
    input  wire                write_done,
    input  wire   [DATA_W-1:0] read_data,
    output logic               pg_wr,
    output logic   [IDX_W-1:0] pg_idx,
    output logic               exec_en,
    output logic               next_instr,
    input  wire                cmd_vld,
    input  wire nnc_pkg::opcode_e cmd_op,
    input  wire         [27:0] cmd_arg,
    output logic               img_addr_inc,
    output logic               img_cnt_dec,
    output logic               rslt_addr_inc,
    input  wire         [27:0] img_addr,
    input  wire                img_cnt_zero,
    input  wire         [27:0] rslt_addr,
    output logic               rdn_weight_vld,
    output logic               dnn_weight_vld,
    output logic  [DATA_W-1:0] weight_data,
    input  wire                img_rdy,
    output logic               img_vld,
    output logic  [DATA_W-1:0] img_data,
    input  wire                res_vld,
    input  wire   [DATA_W-1:0] res_data,
    output logic               res_rdy,
    output logic               done
);

    localparam int MAX_A  = (PROG_PAGES > WEIGHT_PAGES) ? PROG_PAGES : WEIGHT_PAGES;
    localparam int MAX_PG = (MAX_A > IMG_PAGES) ? MAX_A : IMG_PAGES;
    localparam int CNT_W  = $clog2(MAX_PG + 1);

    nnc_pkg::seq_state_e state;
    logic [CNT_W-1:0]    pg_cnt;
    logic [31:0]         prog_q;
    logic [27:0]         ld_addr;
    logic [DATA_W-1:0]   res_q;
    logic                ld_rdn;
    logic                req_go;
    logic                retire;
    logic                cmd_go;
    logic                ld_start;
    logic                last_pg;

    assign cmd_go   = (state == nnc_pkg::EXEC) && !retire && cmd_vld;
    assign ld_start = cmd_go && (cmd_op == nnc_pkg::OP_LOAD_RDN ||
                                 cmd_op == nnc_pkg::OP_LOAD_DNN);

    always_comb begin
        case (state)
            nnc_pkg::FETCH_WAIT: last_pg = (pg_cnt == CNT_W'(PROG_PAGES - 1));
            nnc_pkg::LOAD_WAIT:  last_pg = (pg_cnt == CNT_W'(WEIGHT_PAGES - 1));
            default:             last_pg = (pg_cnt == CNT_W'(IMG_PAGES - 1));
        endcase
    end

    always_comb begin
        read_req       = 1'b0;
        write_req      = 1'b0;
        address        = '0;
        pg_wr          = 1'b0;
        next_instr     = 1'b0;
        img_addr_inc   = 1'b0;
        img_cnt_dec    = 1'b0;
        rslt_addr_inc  = 1'b0;
        rdn_weight_vld = 1'b0;
        dnn_weight_vld = 1'b0;
        img_vld        = 1'b0;
        res_rdy        = 1'b0;
        exec_en        = (state inside {nnc_pkg::EXEC, nnc_pkg::LOAD_WAIT, nnc_pkg::IMG_WAIT,
                                        nnc_pkg::RES_WAIT, nnc_pkg::WRITE_WAIT});
        case (state)
            nnc_pkg::FETCH: begin
                read_req = 1'b1;
                address  = prog_q + 32'(pg_cnt);
            end
            nnc_pkg::FETCH_WAIT: begin
                pg_wr   = data_valid;
                // raise exec_en early so decode starts at pc 0
                exec_en = data_valid && last_pg;
            end
            nnc_pkg::EXEC: begin
                if (retire) begin
                    next_instr = 1'b1;
                end else if (cmd_vld) begin
                    case (cmd_op)
                        nnc_pkg::OP_LOAD_RDN, nnc_pkg::OP_LOAD_DNN, nnc_pkg::OP_HALT: ;
                        nnc_pkg::OP_PROC: next_instr = img_cnt_zero;
                        default:          next_instr = 1'b1;
                    endcase
                end
            end
            nnc_pkg::LOAD_WAIT: begin
                read_req       = req_go;
                address        = {4'b0, ld_addr};
                rdn_weight_vld = data_valid && ld_rdn;
                dnn_weight_vld = data_valid && !ld_rdn;
            end
            nnc_pkg::IMG_WAIT: begin
                // image unit back-pressure holds the read
                read_req     = req_go && img_rdy;
                address      = {4'b0, img_addr};
                img_vld      = data_valid;
                img_addr_inc = data_valid;
            end
            nnc_pkg::RES_WAIT: begin
                res_rdy = 1'b1;
            end
            nnc_pkg::WRITE_WAIT: begin
                write_req     = req_go;
                address       = {4'b0, rslt_addr};
                rslt_addr_inc = write_done;
                img_cnt_dec   = write_done;
            end
            default: ;
        endcase
    end

    assign pg_idx      = pg_cnt[IDX_W-1:0];
    assign write_data  = res_q;
    assign weight_data = read_data;
    assign img_data    = read_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= nnc_pkg::IDLE;
            pg_cnt <= '0;
            ld_rdn <= 1'b0;
            req_go <= 1'b0;
            retire <= 1'b0;
            done   <= 1'b0;
        end else begin
            if (read_req || write_req) begin
                req_go <= 1'b0;
            end
            case (state)
                nnc_pkg::IDLE: if (start) begin
                    pg_cnt <= '0;
                    done   <= 1'b0;
                    state  <= nnc_pkg::FETCH;
                end
                nnc_pkg::FETCH: state <= nnc_pkg::FETCH_WAIT;
                nnc_pkg::FETCH_WAIT: if (data_valid) begin
                    if (last_pg) begin
                        state <= nnc_pkg::EXEC;
                    end else begin
                        pg_cnt <= pg_cnt + 1'b1;
                        state  <= nnc_pkg::FETCH;
                    end
                end
                nnc_pkg::EXEC: begin
                    retire <= 1'b0;
                    if (ld_start) begin
                        ld_rdn <= (cmd_op == nnc_pkg::OP_LOAD_RDN);
                        pg_cnt <= '0;
                        req_go <= 1'b1;
                        state  <= nnc_pkg::LOAD_WAIT;
                    end else if (cmd_go && cmd_op == nnc_pkg::OP_PROC && !img_cnt_zero) begin
                        pg_cnt <= '0;
                        req_go <= 1'b1;
                        state  <= nnc_pkg::IMG_WAIT;
                    end else if (cmd_go && cmd_op == nnc_pkg::OP_HALT) begin
                        done  <= 1'b1;
                        state <= nnc_pkg::IDLE;
                    end
                end
                nnc_pkg::LOAD_WAIT, nnc_pkg::IMG_WAIT: if (data_valid) begin
                    if (!last_pg) begin
                        pg_cnt <= pg_cnt + 1'b1;
                        req_go <= 1'b1;
                    end else if (state == nnc_pkg::LOAD_WAIT) begin
                        retire <= 1'b1;
                        state  <= nnc_pkg::EXEC;
                    end else begin
                        state <= nnc_pkg::RES_WAIT;
                    end
                end
                nnc_pkg::RES_WAIT: if (res_vld) begin
                    req_go <= 1'b1;
                    state  <= nnc_pkg::WRITE_WAIT;
                end
                // back to EXEC, where PROC checks the remaining count
                nnc_pkg::WRITE_WAIT: if (write_done) begin
                    state <= nnc_pkg::EXEC;
                end
                default: state <= nnc_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == nnc_pkg::IDLE && start) begin
            prog_q <= prog_base;
        end
        if (ld_start) begin
            ld_addr <= cmd_arg;
        end else if (state == nnc_pkg::LOAD_WAIT && data_valid) begin
            ld_addr <= ld_addr + 28'd1;
        end
        if (res_rdy && res_vld) begin
            res_q <= res_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/nnc_top.sv */
`default_nettype none

module nnc_top #(
    parameter int DATA_W       = 64,
    parameter int PROG_PAGES   = 8,
    parameter int WEIGHT_PAGES = 4,
    parameter int IMG_PAGES    = 6
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start,
    input  wire        [31:0] prog_base,
    output logic              read_req,
    output logic              write_req,
    output logic       [31:0] address,
    output logic [DATA_W-1:0] write_data,
    input  wire               data_valid,
    input  wire               write_done,
    input  wire  [DATA_W-1:0] read_data,
    output logic              rdn_weight_vld,
    output logic              dnn_weight_vld,
    output logic [DATA_W-1:0] weight_data,
    input  wire               img_rdy,
    output logic              img_vld,
    output logic [DATA_W-1:0] img_data,
    input  wire               res_vld,
    input  wire  [DATA_W-1:0] res_data,
    output logic              res_rdy,
    output logic              done
);

    localparam int IDX_W = $clog2(PROG_PAGES);
    localparam int PC_W  = $clog2(2 * PROG_PAGES);

    logic                 pg_wr;
    logic [IDX_W-1:0]     pg_idx;
    logic [PC_W-1:0]      pc;
    nnc_pkg::instr_u      instr;
    logic                 exec_en;
    logic                 next_instr;
    logic                 cmd_vld;
    nnc_pkg::opcode_e     cmd_op;
    logic [27:0]          cmd_arg;
    logic                 reg_wr;
    nnc_pkg::reg_sel_e    reg_sel;
    logic [23:0]          reg_val;
    logic                 img_addr_inc;
    logic                 img_cnt_dec;
    logic                 rslt_addr_inc;
    logic [27:0]          img_addr;
    logic                 img_cnt_zero;
    logic [27:0]          rslt_addr;

    nnc_regs u_regs (
        .clk, .rst_n, .reg_wr, .reg_sel, .reg_val,
        .img_addr_inc, .img_cnt_dec, .rslt_addr_inc,
        .img_addr, .img_cnt_zero, .rslt_addr
    );

    nnc_page_buf #(.DATA_W(DATA_W), .PROG_PAGES(PROG_PAGES)) u_page_buf (
        .clk, .rst_n, .pg_wr, .pg_idx, .pg_data(read_data), .pc, .instr
    );

    nnc_decode #(.PROG_PAGES(PROG_PAGES)) u_decode (
        .clk, .rst_n, .exec_en, .next_instr, .instr, .pc,
        .cmd_vld, .cmd_op, .cmd_arg, .reg_wr, .reg_sel, .reg_val
    );

    nnc_seq #(
        .DATA_W(DATA_W), .PROG_PAGES(PROG_PAGES),
        .WEIGHT_PAGES(WEIGHT_PAGES), .IMG_PAGES(IMG_PAGES)
    ) u_seq (
        .clk, .rst_n, .start, .prog_base,
        .read_req, .write_req, .address, .write_data, .data_valid, .write_done, .read_data,
        .pg_wr, .pg_idx, .exec_en, .next_instr, .cmd_vld, .cmd_op, .cmd_arg,
        .img_addr_inc, .img_cnt_dec, .rslt_addr_inc, .img_addr, .img_cnt_zero, .rslt_addr,
        .rdn_weight_vld, .dnn_weight_vld, .weight_data,
        .img_rdy, .img_vld, .img_data, .res_vld, .res_data, .res_rdy, .done
    );

endmodule

`default_nettype wire

/* bench/nnc_chk.sv */
`default_nettype none

module nnc_chk (
    input wire clk,
    input wire rst_n,
    input wire read_req,
    input wire write_req,
    input wire data_valid,
    input wire write_done,
    input wire res_rdy
);
    timeunit 1ns;
    timeprecision 1ps;

    logic outstanding;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (read_req || write_req) begin
            outstanding <= 1'b1;
        end else if (data_valid || write_done) begin
            outstanding <= 1'b0;
        end
    end

    req_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_req && write_req))
        else $error("read_req and write_req high in the same cycle");

    // one request at a time on the memory port
    req_single: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding |-> !(read_req || write_req))
        else $error("new memory request while one is outstanding");

    rdy_idle: assert property (@(posedge clk) disable iff (!rst_n)
        res_rdy |-> !outstanding)
        else $error("res_rdy high with a memory request pending");

endmodule

bind nnc_top nnc_chk u_chk (
    .clk(clk), .rst_n(rst_n), .read_req(read_req), .write_req(write_req),
    .data_valid(data_valid), .write_done(write_done), .res_rdy(res_rdy)
);

`default_nettype wire

/* bench/nnc_monitor.sv */
`default_nettype none

module nnc_monitor #(
    parameter int          DATA_W       = 64,
    parameter int          MEM_WORDS    = 512,
    parameter int          PROG_PAGES   = 8,
    parameter int          WEIGHT_PAGES = 4,
    parameter int          IMG_PAGES    = 6,
    parameter logic [27:0] IMG_ADDR     = '0,
    parameter int          IMG_CNT      = 0,
    parameter logic [27:0] RSLT_ADDR    = '0,
    parameter logic [27:0] RDN_ADDR     = '0,
    parameter logic [27:0] DNN_ADDR     = '0
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start,
    input  wire        [31:0] prog_base,
    input  wire               read_req,
    input  wire               write_req,
    input  wire        [31:0] address,
    input  wire  [DATA_W-1:0] write_data,
    input  wire               data_valid,
    input  wire               rdn_weight_vld,
    input  wire               dnn_weight_vld,
    input  wire  [DATA_W-1:0] weight_data,
    input  wire               img_rdy,
    input  wire               img_vld,
    input  wire  [DATA_W-1:0] img_data,
    input  wire               res_vld,
    input  wire  [DATA_W-1:0] res_data,
    input  wire               res_rdy,
    input  wire               done,
    input  logic [DATA_W-1:0] mem [MEM_WORDS],
    output int                err_cnt,
    output int                chk_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int K_PROG = 0;
    localparam int K_RDN  = 1;
    localparam int K_DNN  = 2;
    localparam int K_IMG  = 3;
    localparam int K_WR   = 4;

    int                exp_kind [$];
    logic       [31:0] exp_addr [$];
    int                cur_kind = K_PROG;
    logic       [31:0] cur_addr = '0;
    logic [DATA_W-1:0] last_res = '0;
    logic              started  = 1'b0;
    logic              done_q   = 1'b0;
    logic              start_q  = 1'b0;
    logic              res_wait = 1'b0;
    int                errors   = 0;
    int                checks   = 0;

    assign err_cnt = errors;
    assign chk_cnt = checks;

    function automatic string kind_name(input int kind);
        case (kind)
            K_PROG:  return "fetch";
            K_RDN:   return "rdn load";
            K_DNN:   return "dnn load";
            K_IMG:   return "image";
            default: return "result write";
        endcase
    endfunction

    task automatic compare(input string name, input logic [DATA_W-1:0] expected,
                           input logic [DATA_W-1:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic complain(input string what);
        errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    task automatic push(input int kind, input logic [31:0] addr);
        exp_kind.push_back(kind);
        exp_addr.push_back(addr);
    endtask

    // whole transaction order of one run of the program
    task automatic queue_run(input logic [31:0] base);
        int i;
        int n;
        for (i = 0; i < PROG_PAGES; i++) begin
            push(K_PROG, base + 32'(i));
        end
        for (i = 0; i < WEIGHT_PAGES; i++) begin
            push(K_RDN, {4'h0, RDN_ADDR} + 32'(i));
        end
        for (i = 0; i < WEIGHT_PAGES; i++) begin
            push(K_DNN, {4'h0, DNN_ADDR} + 32'(i));
        end
        for (n = 0; n < IMG_CNT; n++) begin
            for (i = 0; i < IMG_PAGES; i++) begin
                push(K_IMG, {4'h0, IMG_ADDR} + 32'(n * IMG_PAGES + i));
            end
            push(K_WR, {4'h0, RSLT_ADDR} + 32'(n));
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (!started && !start && (read_req || write_req || img_vld || rdn_weight_vld ||
                                       dnn_weight_vld || res_rdy || done)) begin
                complain("control output high after reset before any start");
            end
            if (start) begin
                started = 1'b1;
                queue_run(prog_base);
            end
            // result ready from the last page of an image until the engine answers
            compare("res_rdy", DATA_W'(res_wait), DATA_W'(res_rdy));
            if (data_valid) begin
                compare("rdn_weight_vld", DATA_W'(cur_kind == K_RDN), DATA_W'(rdn_weight_vld));
                compare("dnn_weight_vld", DATA_W'(cur_kind == K_DNN), DATA_W'(dnn_weight_vld));
                compare("img_vld", DATA_W'(cur_kind == K_IMG), DATA_W'(img_vld));
                if (cur_kind == K_RDN || cur_kind == K_DNN) begin
                    compare("weight_data", mem[cur_addr[MEM_AW-1:0]], weight_data);
                end
                if (cur_kind == K_IMG) begin
                    compare("img_data", mem[cur_addr[MEM_AW-1:0]], img_data);
                    if (exp_kind.size() != 0 && exp_kind[0] == K_WR) begin
                        res_wait = 1'b1;
                    end
                end
            end else if (rdn_weight_vld || dnn_weight_vld || img_vld) begin
                complain("weight or image strobe without data_valid");
            end
            if (read_req || write_req) begin
                if (exp_kind.size() == 0) begin
                    complain("memory request issued with no transaction expected");
                end else begin
                    cur_kind = exp_kind.pop_front();
                    cur_addr = exp_addr.pop_front();
                    if (write_req != (cur_kind == K_WR)) begin
                        complain($sformatf("wrong request type for %s", kind_name(cur_kind)));
                    end
                    compare($sformatf("%s address", kind_name(cur_kind)),
                            DATA_W'(cur_addr), DATA_W'(address));
                    if (write_req) begin
                        compare("result write_data", last_res, write_data);
                    end
                    if (read_req && cur_kind == K_IMG && !img_rdy) begin
                        complain("image read issued while img_rdy was low");
                    end
                end
            end
            if (res_vld && res_wait) begin
                last_res = res_data;
                res_wait = 1'b0;
            end
            if (done && !done_q && exp_kind.size() != 0) begin
                complain($sformatf("done rose with %0d transactions still expected",
                                   exp_kind.size()));
            end
            if (done_q && !done && !start_q) begin
                complain("done fell without a new start");
            end
            done_q  = done;
            start_q = start;
        end
    end

endmodule

`default_nettype wire

/* bench/nnc_tb.sv */
`default_nettype none

module nnc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          DATA_W       = 64;
    localparam int          PROG_PAGES   = 8;
    localparam int          WEIGHT_PAGES = 4;
    localparam int          IMG_PAGES    = 6;
    localparam int          MEM_WORDS    = 512;
    localparam int          MEM_AW       = $clog2(MEM_WORDS);
    localparam logic [31:0] PROG_A       = 32'h040;
    localparam logic [31:0] PROG_B       = 32'h060;
    localparam logic [27:0] IMG_ADDR     = 28'h100;
    localparam int          IMG_CNT      = 3;
    localparam logic [27:0] RSLT_ADDR    = 28'h180;
    localparam logic [27:0] RDN_ADDR     = 28'h0c0;
    localparam logic [27:0] DNN_ADDR     = 28'h0d0;
    localparam int          RUN_LIMIT    = 2000;

    logic              clk        = 1'b0;
    logic              rst_n      = 1'b0;
    logic              start      = 1'b0;
    logic       [31:0] prog_base  = '0;
    logic              data_valid = 1'b0;
    logic              write_done = 1'b0;
    logic [DATA_W-1:0] read_data  = '0;
    logic              img_rdy    = 1'b0;
    logic              res_vld    = 1'b0;
    logic [DATA_W-1:0] res_data   = '0;
    logic              read_req;
    logic              write_req;
    logic       [31:0] address;
    logic [DATA_W-1:0] write_data;
    logic              rdn_weight_vld;
    logic              dnn_weight_vld;
    logic [DATA_W-1:0] weight_data;
    logic              img_vld;
    logic [DATA_W-1:0] img_data;
    logic              res_rdy;
    logic              done;

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic              mem_ready   = 1'b0;
    logic       [31:0] rng         = 32'h29ab;
    logic              req_rd_q    = 1'b0;
    logic              req_wr_q    = 1'b0;
    logic       [31:0] req_addr_q  = '0;
    logic [DATA_W-1:0] req_wdata_q = '0;
    logic              mem_busy    = 1'b0;
    logic              mem_wr      = 1'b0;
    int                mem_wait    = 0;
    logic       [31:0] mem_addr    = '0;
    logic [DATA_W-1:0] mem_wdata   = '0;
    logic              eng_armed   = 1'b0;
    int                eng_wait    = 0;
    logic              timed_out   = 1'b0;
    int                err_cnt;
    int                chk_cnt;

    always #10 clk = ~clk;

    nnc_top #(
        .DATA_W(DATA_W), .PROG_PAGES(PROG_PAGES),
        .WEIGHT_PAGES(WEIGHT_PAGES), .IMG_PAGES(IMG_PAGES)
    ) DUT (
        .clk, .rst_n, .start, .prog_base,
        .read_req, .write_req, .address, .write_data, .data_valid, .write_done, .read_data,
        .rdn_weight_vld, .dnn_weight_vld, .weight_data,
        .img_rdy, .img_vld, .img_data, .res_vld, .res_data, .res_rdy, .done
    );

    nnc_monitor #(
        .DATA_W(DATA_W), .MEM_WORDS(MEM_WORDS), .PROG_PAGES(PROG_PAGES),
        .WEIGHT_PAGES(WEIGHT_PAGES), .IMG_PAGES(IMG_PAGES), .IMG_ADDR(IMG_ADDR),
        .IMG_CNT(IMG_CNT), .RSLT_ADDR(RSLT_ADDR), .RDN_ADDR(RDN_ADDR), .DNN_ADDR(DNN_ADDR)
    ) u_monitor (
        .clk, .rst_n, .start, .prog_base,
        .read_req, .write_req, .address, .write_data, .data_valid,
        .rdn_weight_vld, .dnn_weight_vld, .weight_data,
        .img_rdy, .img_vld, .img_data, .res_vld, .res_data, .res_rdy, .done,
        .mem, .err_cnt, .chk_cnt
    );

    function automatic logic [31:0] next_random();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng;
    endfunction

    function automatic nnc_pkg::instr_u reg_instr(input nnc_pkg::reg_sel_e sel,
                                                  input logic [23:0] val);
        nnc_pkg::instr_u w;
        w.regv.op    = nnc_pkg::OP_SETREG;
        w.regv.sel   = sel;
        w.regv.spare = 2'b00;
        w.regv.val   = val;
        return w;
    endfunction

    function automatic nnc_pkg::instr_u cmd_instr(input nnc_pkg::opcode_e op,
                                                  input logic [27:0] arg);
        nnc_pkg::instr_u w;
        w.cmd.op  = op;
        w.cmd.arg = arg;
        return w;
    endfunction

    // two instructions per page, even pc in the low word
    task automatic load_program(input logic [31:0] base);
        nnc_pkg::instr_u prog [2*PROG_PAGES];
        int i;
        for (i = 0; i < 2 * PROG_PAGES; i++) begin
            prog[i] = cmd_instr(nnc_pkg::OP_NOP, 28'd0);
        end
        prog[0] = reg_instr(nnc_pkg::SEL_IMG_ADDR, IMG_ADDR[23:0]);
        prog[1] = reg_instr(nnc_pkg::SEL_IMG_CNT, 24'(IMG_CNT));
        prog[2] = reg_instr(nnc_pkg::SEL_RSLT_ADDR, RSLT_ADDR[23:0]);
        prog[3] = cmd_instr(nnc_pkg::OP_LOAD_RDN, RDN_ADDR);
        prog[4] = cmd_instr(nnc_pkg::OP_LOAD_DNN, DNN_ADDR);
        prog[5] = cmd_instr(nnc_pkg::OP_PROC, 28'd0);
        prog[6] = cmd_instr(nnc_pkg::OP_HALT, 28'd0);
        for (i = 0; i < PROG_PAGES; i++) begin
            mem[MEM_AW'(base) + MEM_AW'(i)] = {prog[2*i+1], prog[2*i]};
        end
    endtask

    always @(posedge clk) begin
        req_rd_q    <= read_req;
        req_wr_q    <= write_req;
        req_addr_q  <= address;
        req_wdata_q <= write_data;
    end

    // memory, image unit and engine, all driven on the falling edge
    always @(negedge clk) begin
        data_valid = 1'b0;
        write_done = 1'b0;
        res_vld    = 1'b0;
        if (!rst_n && !mem_ready) begin
            for (int j = 0; j < MEM_WORDS; j++) begin
                mem[MEM_AW'(j)] = {next_random(), next_random()};
            end
            load_program(PROG_A);
            load_program(PROG_B);
            mem_ready = 1'b1;
        end else if (rst_n) begin
            // roughly one cycle in four without img_rdy
            img_rdy = (next_random() >> 30) != 32'd0;
            if (req_rd_q || req_wr_q) begin
                mem_busy  = 1'b1;
                mem_wr    = req_wr_q;
                mem_addr  = req_addr_q;
                mem_wdata = req_wdata_q;
                mem_wait  = int'(next_random() >> 30);
            end
            if (mem_busy) begin
                if (mem_wait == 0) begin
                    mem_busy = 1'b0;
                    if (mem_wr) begin
                        mem[mem_addr[MEM_AW-1:0]] = mem_wdata;
                        write_done = 1'b1;
                    end else begin
                        read_data  = mem[mem_addr[MEM_AW-1:0]];
                        data_valid = 1'b1;
                    end
                end else begin
                    mem_wait = mem_wait - 1;
                end
            end
            if (res_rdy && !eng_armed) begin
                eng_armed = 1'b1;
                eng_wait  = int'(next_random() >> 30);
            end
            if (eng_armed) begin
                if (eng_wait == 0) begin
                    eng_armed = 1'b0;
                    res_vld   = 1'b1;
                    res_data  = {next_random(), next_random()};
                end else begin
                    eng_wait = eng_wait - 1;
                end
            end
        end
    end

    task automatic run_program(input logic [31:0] base);
        int n;
        prog_base = base;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        n     = 0;
        while (!done && n < RUN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("timeout: done did not rise within %0d cycles of start at %h",
                     RUN_LIMIT, base);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);
        run_program(PROG_A);
        if (!timed_out) begin
            repeat (12) @(negedge clk);
            run_program(PROG_B);
        end
        // idle window after the last halt
        if (!timed_out) begin
            repeat (12) @(negedge clk);
        end
        $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timed_out);
        if (err_cnt == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/nnc_pkg.sv
rtl/nnc_regs.sv
rtl/nnc_page_buf.sv
rtl/nnc_decode.sv
rtl/nnc_seq.sv
rtl/nnc_top.sv
bench/nnc_chk.sv
bench/nnc_monitor.sv
bench/nnc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run nnc_tb with Verilator, then scan the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module nnc_tb -f vlog.f -o nnc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/nnc_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
